// File: project.f
hdl/raggedstone_pkg.sv
hdl/link_chan_if.sv
hdl/host_pkt_fifo.sv
hdl/link_rx_select.sv
hdl/status_led_gen.sv
hdl/raggedstone_bridge_top.sv
tests/tb_clock_gen.sv
tests/tb_top.sv

// File: Bender.yml
package:
  name: raggedstone_bridge

sources:
  # RTL in compile order
  - files:
      - hdl/raggedstone_pkg.sv
      - hdl/link_chan_if.sv
      - hdl/host_pkt_fifo.sv
      - hdl/link_rx_select.sv
      - hdl/status_led_gen.sv
      - hdl/raggedstone_bridge_top.sv

  # Testbench, top module tb_top
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_top.sv

// File: tests/tb_top.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the slow-side packet bridge
// PULSE_CYCLES and BLINK_BIT are shortened so LED timing fits a short run
// Inputs change 2 ns after the rising edge, all sampling is on the
// falling edge where driven inputs and DUT outputs have settled
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_top;

	localparam int FIFO_ADDR_BITS = 4;
	localparam int FIFO_DEPTH     = (1 << FIFO_ADDR_BITS) - 1; // 15 packets
	localparam int HIGH_WATER     = 8;
	localparam int PULSE_CYCLES   = 8;
	localparam int BLINK_BIT      = 4;
	localparam int BLINK_WINDOW   = 2 * (2 ** (BLINK_BIT + 1)); // Two blink periods
	localparam int MAX_CYCLES     = 3000; // Tests need about 300, wide margin
	localparam int NCH            = raggedstone_pkg::NUM_CHANS;
	localparam int LED_L          = raggedstone_pkg::LED_LINK;
	localparam int LED_H          = raggedstone_pkg::LED_HOST;

	logic                                 clk;
	logic                                 rst_i;
	raggedstone_pkg::pkt_t                host_rx_data_i;
	logic                                 host_rx_vld_i;
	logic                                 host_rx_rdy_o;
	logic                                 host_cts_o;
	raggedstone_pkg::pkt_t                host_tx_data_o;
	logic                                 host_tx_vld_o;
	logic                                 host_tx_rdy_i;
	logic                                 host_ready_i;
	raggedstone_pkg::pkt_t                link_tx_data_o;
	logic                                 link_tx_vld_o;
	logic                                 link_tx_rdy_i;
	raggedstone_pkg::pkt_t                link_rx_data_i [NCH];
	logic [NCH-1:0]                       link_rx_vld_i;
	logic [NCH-1:0]                       link_rx_rdy_o;
	logic                                 link_up_i;
	logic                                 version_mismatch_i;
	logic [raggedstone_pkg::NUM_LEDS-1:0] leds_o;

	// Reference models, updated on the falling edge
	raggedstone_pkg::pkt_t link_exp [$]; // Host packets owed to the link
	raggedstone_pkg::pkt_t host_exp [$]; // Channel 0 packets owed to the host
	raggedstone_pkg::pkt_t exp_pkt;
	int   occ_q;       // FIFO occupancy after the coming edge
	int   idle_link_q; // Edges without link transfer
	int   idle_host_q;
	logic act_link;
	logic act_host;

	integer seed      = 32'h901b;
	int     err_cnt   = 0;
	int     err_base  = 0;
	int     test_cnt  = 0;
	int     fail_cnt  = 0;
	int     cycle_cnt = 0;

	tb_clock_gen #(.PERIOD_NS (20)) u_clk (.clk_o (clk));

	raggedstone_bridge_top #(
		.FIFO_ADDR_BITS (FIFO_ADDR_BITS),
		.HIGH_WATER     (HIGH_WATER),
		.PULSE_CYCLES   (PULSE_CYCLES),
		.BLINK_BIT      (BLINK_BIT)
	) u_dut (
		.clk_i              (clk),
		.rst_i              (rst_i),
		.host_rx_data_i     (host_rx_data_i),
		.host_rx_vld_i      (host_rx_vld_i),
		.host_rx_rdy_o      (host_rx_rdy_o),
		.host_cts_o         (host_cts_o),
		.host_tx_data_o     (host_tx_data_o),
		.host_tx_vld_o      (host_tx_vld_o),
		.host_tx_rdy_i      (host_tx_rdy_i),
		.host_ready_i       (host_ready_i),
		.link_tx_data_o     (link_tx_data_o),
		.link_tx_vld_o      (link_tx_vld_o),
		.link_tx_rdy_i      (link_tx_rdy_i),
		.link_rx_data_i     (link_rx_data_i),
		.link_rx_vld_i      (link_rx_vld_i),
		.link_rx_rdy_o      (link_rx_rdy_o),
		.link_up_i          (link_up_i),
		.version_mismatch_i (version_mismatch_i),
		.leds_o             (leds_o)
	);

	// Transfers seen at the ports, per LED
	assign act_link = (|(link_rx_vld_i & link_rx_rdy_o)) | (link_tx_vld_o & link_tx_rdy_i);
	assign act_host = (host_rx_vld_i & host_rx_rdy_o) | (host_tx_vld_o & host_tx_rdy_i);

	//////////////////////////////////////////////////////////////////////
	// Reporting and stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [71:0] got,
		input logic [71:0] exp);
		$display("** Error %s: got %0h expected %0h", name, got, exp);
		err_cnt++;
	endtask

	task automatic report_failure(input string what);
		$display("Check failed: %s", what);
		err_cnt++;
	endtask

	function automatic raggedstone_pkg::pkt_t rand_pkt();
		logic [95:0] r;
		r = {$random(seed), $random(seed), $random(seed)};
		return r[71:0];
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// Hold one packet on the host port until the FIFO takes it
	task automatic send_host(input raggedstone_pkg::pkt_t pkt);
		logic taken;
		host_rx_data_i = pkt;
		host_rx_vld_i  = 1'b1;
		taken          = 1'b0;
		while (!taken)
		begin
			@(negedge clk);
			taken = host_rx_rdy_o; // Transfer on the coming edge
			@(posedge clk);
			#2;
		end
		host_rx_vld_i = 1'b0;
	endtask

	// Both scoreboards empty
	task automatic drain();
		do
			@(posedge clk);
		while (link_exp.size() != 0 || host_exp.size() != 0);
		#2;
	endtask

	task automatic check_leds(input logic [raggedstone_pkg::NUM_LEDS-1:0] exp);
		@(negedge clk);
		if (leds_o !== exp)
			report_mismatch("leds_o", leds_o, exp);
		@(posedge clk);
		#2;
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (err_cnt == err_base)
			$display("Test %0d %s: PASS", test_cnt, name);
		else
		begin
			fail_cnt++;
			$display("Test %0d %s: FAIL, %0d errors", test_cnt, name, err_cnt - err_base);
		end
		err_base = err_cnt;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Models and scoreboards
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (rst_i)
		begin
			occ_q       <= 0;
			idle_link_q <= 0;
			idle_host_q <= 0;
		end
		else
		begin
			occ_q <= occ_q + (host_rx_vld_i && host_rx_rdy_o) - (link_tx_vld_o && link_tx_rdy_i);
			idle_link_q <= act_link ? 0 : ((idle_link_q < 255) ? idle_link_q + 1 : 255);
			idle_host_q <= act_host ? 0 : ((idle_host_q < 255) ? idle_host_q + 1 : 255);

			if (host_rx_vld_i && host_rx_rdy_o)
				link_exp.push_back(host_rx_data_i);
			if (link_tx_vld_o && link_tx_rdy_i)
			begin
				if (link_exp.size() == 0)
					report_failure("packet on link_tx_data_o that the host never sent");
				else
				begin
					exp_pkt = link_exp.pop_front();
					if (link_tx_data_o !== exp_pkt)
						report_mismatch("link_tx_data_o", link_tx_data_o, exp_pkt);
				end
			end

			if (link_rx_vld_i[0] && link_rx_rdy_o[0])
				host_exp.push_back(link_rx_data_i[0]); // Only channel 0 is owed
			if (host_tx_vld_o && host_tx_rdy_i)
			begin
				if (host_exp.size() == 0)
					report_failure("packet on host_tx_data_o not received on channel 0");
				else
				begin
					exp_pkt = host_exp.pop_front();
					if (host_tx_data_o !== exp_pkt)
						report_mismatch("host_tx_data_o", host_tx_data_o, exp_pkt);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checking assertions, all on the falling edge
	//////////////////////////////////////////////////////////////////////

	a_reset_state: assert property (@(negedge clk) $fell(rst_i) |->
		{link_tx_vld_o, host_tx_vld_o, host_rx_rdy_o, host_cts_o, leds_o} == 6'b00_1100)
		else report_mismatch("{link_tx_vld_o,host_tx_vld_o,host_rx_rdy_o,host_cts_o,leds_o}",
			{link_tx_vld_o, host_tx_vld_o, host_rx_rdy_o, host_cts_o, leds_o}, 6'b00_1100);

	a_other_chans_rdy: assert property (@(negedge clk) disable iff (rst_i)
		link_rx_rdy_o[NCH-1:1] == '1)
		else report_mismatch("link_rx_rdy_o[7:1]", link_rx_rdy_o[NCH-1:1], 7'h7f);

	// Channel 0 ready while the output register is empty or being taken
	a_ch0_rdy: assert property (@(negedge clk) disable iff (rst_i)
		link_rx_rdy_o[0] == (!host_tx_vld_o || host_tx_rdy_i))
		else report_mismatch("link_rx_rdy_o[0]", link_rx_rdy_o[0], !link_rx_rdy_o[0]);

	// Ready low only when full, valid whenever not empty
	a_fifo_rdy: assert property (@(negedge clk) disable iff (rst_i)
		host_rx_rdy_o == (occ_q != FIFO_DEPTH))
		else report_mismatch("host_rx_rdy_o", host_rx_rdy_o, !host_rx_rdy_o);

	a_fifo_vld: assert property (@(negedge clk) disable iff (rst_i)
		link_tx_vld_o == (occ_q != 0))
		else report_mismatch("link_tx_vld_o", link_tx_vld_o, !link_tx_vld_o);

	// CTS trails occupancy by one cycle
	a_cts: assert property (@(negedge clk) disable iff (rst_i)
		host_cts_o == ($past(occ_q) < HIGH_WATER))
		else report_mismatch("host_cts_o", host_cts_o, !host_cts_o);

	a_link_tx_hold: assert property (@(negedge clk) disable iff (rst_i)
		link_tx_vld_o && !link_tx_rdy_i |=> link_tx_vld_o && $stable(link_tx_data_o))
		else report_failure("link_tx_data_o changed while the link stalled");

	a_host_tx_hold: assert property (@(negedge clk) disable iff (rst_i)
		host_tx_vld_o && !host_tx_rdy_i |=> host_tx_vld_o && $stable(host_tx_data_o))
		else report_failure("host_tx_data_o changed while the host stalled");

	// Not connected, LED dark
	a_link_off: assert property (@(negedge clk) disable iff (rst_i)
		!link_up_i |=> !leds_o[LED_L])
		else report_mismatch("leds_o[link]", leds_o[LED_L], 1'b0);

	a_host_off: assert property (@(negedge clk) disable iff (rst_i)
		!host_ready_i |=> !leds_o[LED_H])
		else report_mismatch("leds_o[host]", leds_o[LED_H], 1'b0);

	// Transfer darkens the LED on the next cycle
	a_link_dark: assert property (@(negedge clk) disable iff (rst_i)
		act_link && link_up_i && !version_mismatch_i |=> !leds_o[LED_L])
		else report_mismatch("leds_o[link]", leds_o[LED_L], 1'b0);

	a_host_dark: assert property (@(negedge clk) disable iff (rst_i)
		act_host && host_ready_i |=> !leds_o[LED_H])
		else report_mismatch("leds_o[host]", leds_o[LED_H], 1'b0);

	// Pulse runs PULSE_CYCLES edges, the LED follows one edge later
	a_link_relight: assert property (@(negedge clk) disable iff (rst_i)
		(idle_link_q >= PULSE_CYCLES + 1) && $past(link_up_i && !version_mismatch_i)
		|-> leds_o[LED_L])
		else report_mismatch("leds_o[link]", leds_o[LED_L], 1'b1);

	a_host_relight: assert property (@(negedge clk) disable iff (rst_i)
		(idle_host_q >= PULSE_CYCLES + 1) && $past(host_ready_i) |-> leds_o[LED_H])
		else report_mismatch("leds_o[host]", leds_o[LED_H], 1'b1);

	// Watchdog
	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("Timeout: run stopped after %0d cycles", cycle_cnt);
			$display("Finished with errors");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] rnd;
		logic        ch0_taken;
		logic        seen_lo;
		logic        seen_hi;

		rst_i              = 1'b1;
		host_rx_data_i     = '0;
		host_rx_vld_i      = 1'b0;
		host_tx_rdy_i      = 1'b1;
		host_ready_i       = 1'b1;
		link_tx_rdy_i      = 1'b1;
		link_rx_vld_i      = '0;
		link_up_i          = 1'b1;
		version_mismatch_i = 1'b0;
		for (int c = 0; c < NCH; c++)
			link_rx_data_i[c] = '0;

		repeat (5) @(posedge clk);
		#2;
		rst_i = 1'b0;

		wait_cycles(2); // Reset state seen by a_reset_state
		end_test("reset");

		for (int i = 0; i < 20; i++)
			send_host(rand_pkt());
		drain();
		end_test("host to link");

		// Fill the FIFO against a stalled link
		link_tx_rdy_i = 1'b0;
		for (int i = 0; i < FIFO_DEPTH; i++)
			send_host(rand_pkt());
		host_rx_data_i = rand_pkt(); // Refused while full
		host_rx_vld_i  = 1'b1;
		wait_cycles(3);
		host_rx_vld_i  = 1'b0;
		link_tx_rdy_i  = 1'b1;
		drain();
		end_test("back-pressure");

		// Random traffic on all channels, host stalls now and then
		ch0_taken = 1'b1;
		for (int i = 0; i < 40; i++)
		begin
			for (int c = 0; c < NCH; c++)
			begin
				if (c != 0 || ch0_taken || !link_rx_vld_i[0]) // Keep a stalled ch 0 packet
				begin
					rnd = $random(seed);
					link_rx_vld_i[c]  = rnd[0];
					link_rx_data_i[c] = rand_pkt();
				end
			end
			rnd = $random(seed);
			host_tx_rdy_i = (rnd[1:0] != 2'b00); // Stall one cycle in four
			@(negedge clk);
			ch0_taken = link_rx_rdy_o[0];
			@(posedge clk);
			#2;
		end
		link_rx_vld_i = '0;
		host_tx_rdy_i = 1'b1;
		drain();
		end_test("link to host");

		wait_cycles(PULSE_CYCLES + 4);
		check_leds(2'b11);
		send_host(rand_pkt()); // Host then link transfer
		drain();
		wait_cycles(PULSE_CYCLES + 4);
		host_ready_i = 1'b0;
		wait_cycles(3);
		host_ready_i = 1'b1;
		link_up_i    = 1'b0;
		wait_cycles(3);
		link_up_i    = 1'b1;
		link_rx_vld_i[5]  = 1'b1; // Dropped channel, link LED only
		link_rx_data_i[5] = rand_pkt();
		wait_cycles(1);
		link_rx_vld_i[5]  = 1'b0;
		wait_cycles(PULSE_CYCLES + 4);
		check_leds(2'b11);
		end_test("LEDs");

		seen_lo = 1'b0;
		seen_hi = 1'b0;
		version_mismatch_i = 1'b1;
		for (int i = 0; i < BLINK_WINDOW; i++)
		begin
			@(negedge clk);
			if (leds_o[LED_L])
				seen_hi = 1'b1;
			else
				seen_lo = 1'b1;
			@(posedge clk);
			#2;
		end
		if (!(seen_lo && seen_hi))
			report_failure("link LED did not blink during version mismatch");
		version_mismatch_i = 1'b0;
		wait_cycles(PULSE_CYCLES + 4);
		check_leds(2'b11);
		end_test("error blink");

		$display("Tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// Free-running testbench clock, starts low
// First rising edge comes half a period after time zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 20
) (
	output logic clk_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD_NS / 2) clk_o = ~clk_o; // 50 % duty
	end

endmodule

`default_nettype wire

// File: hdl/raggedstone_bridge_top.sv
//////////////////////////////////////////////////////////////////////
// Slow-side bridge between a host packet port and link channel 0
// Single clock domain, synchronous active-high reset
// Link channels 1 to 7 are received and dropped, never transmitted
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module raggedstone_bridge_top #(
	parameter int FIFO_ADDR_BITS = raggedstone_pkg::DEF_FIFO_ADDR_BITS,
	parameter int HIGH_WATER     = raggedstone_pkg::DEF_HIGH_WATER,
	parameter int PULSE_CYCLES   = raggedstone_pkg::DEF_PULSE_CYCLES,
	parameter int BLINK_BIT      = raggedstone_pkg::DEF_BLINK_BIT
) (
	input  wire                                  clk_i,
	input  wire                                  rst_i,
	// Host to link
	input  wire raggedstone_pkg::pkt_t           host_rx_data_i,
	input  wire                                  host_rx_vld_i,
	output logic                                 host_rx_rdy_o,
	output logic                                 host_cts_o,
	// Link to host
	output raggedstone_pkg::pkt_t                host_tx_data_o,
	output logic                                 host_tx_vld_o,
	input  wire                                  host_tx_rdy_i,
	input  wire                                  host_ready_i, // Host connected
	// Link transmit, channel 0
	output raggedstone_pkg::pkt_t                link_tx_data_o,
	output logic                                 link_tx_vld_o,
	input  wire                                  link_tx_rdy_i,
	// Link receive, all channels
	input  wire raggedstone_pkg::pkt_t           link_rx_data_i [raggedstone_pkg::NUM_CHANS],
	input  wire [raggedstone_pkg::NUM_CHANS-1:0] link_rx_vld_i,
	output logic [raggedstone_pkg::NUM_CHANS-1:0] link_rx_rdy_o,
	// Link status
	input  wire                                  link_up_i,
	input  wire                                  version_mismatch_i,
	output logic [raggedstone_pkg::NUM_LEDS-1:0]  leds_o
);

	//////////////////////////////////////////////////////////////////////
	// Link channel bundle
	//////////////////////////////////////////////////////////////////////

	link_chan_if link ();

	assign link.rx_data   = link_rx_data_i;
	assign link.rx_vld    = link_rx_vld_i;
	assign link_rx_rdy_o  = link.rx_rdy;
	assign link.tx_rdy    = link_tx_rdy_i;
	assign link_tx_data_o = link.tx_data;
	assign link_tx_vld_o  = link.tx_vld;

	//////////////////////////////////////////////////////////////////////
	// Datapath and status
	//////////////////////////////////////////////////////////////////////

	// Host packets buffered onto link channel 0
	host_pkt_fifo #(
		.ADDR_BITS  (FIFO_ADDR_BITS),
		.HIGH_WATER (HIGH_WATER)
	) u_fifo (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.wr_data_i (host_rx_data_i),
		.wr_vld_i  (host_rx_vld_i),
		.wr_rdy_o  (host_rx_rdy_o),
		.cts_o     (host_cts_o),
		.rd_data_o (link.tx_data), // Drives the tx_src side
		.rd_vld_o  (link.tx_vld),
		.rd_rdy_i  (link.tx_rdy)
	);

	// Channel 0 to host, rest dropped
	link_rx_select u_rx_sel (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.link           (link.rx_sink),
		.host_tx_data_o (host_tx_data_o),
		.host_tx_vld_o  (host_tx_vld_o),
		.host_tx_rdy_i  (host_tx_rdy_i)
	);

	status_led_gen #(
		.PULSE_CYCLES (PULSE_CYCLES),
		.BLINK_BIT    (BLINK_BIT)
	) u_leds (
		.clk_i              (clk_i),
		.rst_i              (rst_i),
		.link               (link.monitor),
		.host_rx_vld_i      (host_rx_vld_i),
		.host_rx_rdy_i      (host_rx_rdy_o), // FIFO ready seen by host
		.host_tx_vld_i      (host_tx_vld_o),
		.host_tx_rdy_i      (host_tx_rdy_i),
		.host_ready_i       (host_ready_i),
		.link_up_i          (link_up_i),
		.version_mismatch_i (version_mismatch_i),
		.leds_o             (leds_o)
	);

endmodule

`default_nettype wire

// File: hdl/status_led_gen.sv
//////////////////////////////////////////////////////////////////////
// Status LEDs for link and host, both registered
// Off when not connected, blink on error (link only), else on
// Each transfer darkens the LED for PULSE_CYCLES, retriggerable
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module status_led_gen #(
	parameter int PULSE_CYCLES = raggedstone_pkg::DEF_PULSE_CYCLES,
	parameter int BLINK_BIT    = raggedstone_pkg::DEF_BLINK_BIT
) (
	input  wire                                 clk_i,
	input  wire                                 rst_i,
	link_chan_if.monitor                        link,
	// Host packet port handshakes
	input  wire                                 host_rx_vld_i,
	input  wire                                 host_rx_rdy_i,
	input  wire                                 host_tx_vld_i,
	input  wire                                 host_tx_rdy_i,
	// Connection state
	input  wire                                 host_ready_i,
	input  wire                                 link_up_i,
	input  wire                                 version_mismatch_i,
	output logic [raggedstone_pkg::NUM_LEDS-1:0] leds_o
);

	localparam int CNT_BITS = $clog2(PULSE_CYCLES + 1);

	logic [raggedstone_pkg::NUM_LEDS-1:0] activity;
	logic [raggedstone_pkg::NUM_LEDS-1:0] connected;
	logic [raggedstone_pkg::NUM_LEDS-1:0] error;

	logic [CNT_BITS-1:0] pulse_q [raggedstone_pkg::NUM_LEDS]; // Dark time left
	logic [BLINK_BIT:0]  blink_q; // Free running

	//////////////////////////////////////////////////////////////////////
	// Per-device inputs
	//////////////////////////////////////////////////////////////////////

	// Any transfer on any link channel, either direction
	assign activity[raggedstone_pkg::LED_LINK] = (|(link.rx_vld & link.rx_rdy))
	                                           | (link.tx_vld & link.tx_rdy);
	assign activity[raggedstone_pkg::LED_HOST] = (host_rx_vld_i & host_rx_rdy_i)
	                                           | (host_tx_vld_i & host_tx_rdy_i);

	assign connected[raggedstone_pkg::LED_LINK] = link_up_i;
	assign connected[raggedstone_pkg::LED_HOST] = host_ready_i;

	assign error[raggedstone_pkg::LED_LINK] = version_mismatch_i;
	assign error[raggedstone_pkg::LED_HOST] = 1'b0; // Host has no version check

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			blink_q <= '0;
		else
			blink_q <= blink_q + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Pulse stretch and LED decode, one copy per device
	//////////////////////////////////////////////////////////////////////

	for (genvar d = 0; d < raggedstone_pkg::NUM_LEDS; d++)
	begin : g_dev
		always_ff @(posedge clk_i)
		begin
			if (rst_i)
			begin
				pulse_q[d] <= '0;
				leds_o[d]  <= 1'b0;
			end
			else
			begin
				if (activity[d])
					pulse_q[d] <= CNT_BITS'(PULSE_CYCLES); // Retrigger
				else if (pulse_q[d] != '0)
					pulse_q[d] <= pulse_q[d] - 1'b1;

				if (!connected[d])
					leds_o[d] <= 1'b0;
				else if (error[d])
					leds_o[d] <= blink_q[BLINK_BIT];
				else
					leds_o[d] <= !activity[d] && (pulse_q[d] == '0); // Dark during pulse
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/link_rx_select.sv
//////////////////////////////////////////////////////////////////////
// Link receive sink, channel 0 goes to the host via one register
// Channels 1 to 7 are always ready and their packets are dropped
// Channel 0 ready looks through to host_tx_rdy_i in the same cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module link_rx_select (
	input  wire                   clk_i,
	input  wire                   rst_i,
	link_chan_if.rx_sink          link,
	// Host side output register
	output raggedstone_pkg::pkt_t host_tx_data_o,
	output logic                  host_tx_vld_o,
	input  wire                   host_tx_rdy_i
);

	raggedstone_pkg::pkt_t data_q; // Payload, no reset needed
	logic                  vld_q;

	logic ch0_rdy;
	logic ch0_load;

	// Empty, or emptying this cycle
	assign ch0_rdy  = !vld_q || host_tx_rdy_i;
	assign ch0_load = link.rx_vld[0] & ch0_rdy;

	// Other channels just swallow whatever arrives
	assign link.rx_rdy = {{(raggedstone_pkg::NUM_CHANS-1){1'b1}}, ch0_rdy};

	assign host_tx_data_o = data_q;
	assign host_tx_vld_o  = vld_q;

	always_ff @(posedge clk_i)
	begin
		if (ch0_load)
			data_q <= link.rx_data[0];
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			vld_q <= 1'b0;
		else if (ch0_load)
			vld_q <= 1'b1; // New packet replaces any accepted one
		else if (host_tx_rdy_i)
			vld_q <= 1'b0; // Host took it
	end

	// Stalled output holds both valid and data
	a_hold_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
		host_tx_vld_o && !host_tx_rdy_i |=> host_tx_vld_o && $stable(host_tx_data_o));

endmodule

`default_nettype wire

// File: hdl/host_pkt_fifo.sv
//////////////////////////////////////////////////////////////////////
// Host to link packet buffer, (1 << ADDR_BITS) - 1 entries
// Read data comes straight from the array, so rd_data_o is unregistered
// CTS is registered and trails the occupancy by one cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module host_pkt_fifo #(
	parameter int ADDR_BITS  = raggedstone_pkg::DEF_FIFO_ADDR_BITS,
	parameter int HIGH_WATER = raggedstone_pkg::DEF_HIGH_WATER
) (
	input  wire                   clk_i,
	input  wire                   rst_i,
	// Write side, from the host
	input  wire raggedstone_pkg::pkt_t wr_data_i,
	input  wire                   wr_vld_i,
	output logic                  wr_rdy_o,
	output logic                  cts_o,
	// Read side, toward the link
	output raggedstone_pkg::pkt_t rd_data_o,
	output logic                  rd_vld_o,
	input  wire                   rd_rdy_i
);

	// One slot stays free so pointers wrap at a power of two
	localparam logic [ADDR_BITS:0] DEPTH = (1 << ADDR_BITS) - 1;

	raggedstone_pkg::pkt_t mem_q [1 << ADDR_BITS]; // Packet store

	logic [ADDR_BITS-1:0] wr_ptr_q;
	logic [ADDR_BITS-1:0] rd_ptr_q;
	logic [ADDR_BITS:0]   count_q; // Extra bit to catch overflow
	logic                 cts_q;

	logic wr_en;
	logic rd_en;

	assign wr_rdy_o = (count_q != DEPTH); // Registered state only
	assign rd_vld_o = (count_q != '0);
	assign rd_data_o = mem_q[rd_ptr_q]; // Head of queue
	assign cts_o = cts_q;

	assign wr_en = wr_vld_i & wr_rdy_o;
	assign rd_en = rd_vld_o & rd_rdy_i;

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i)
	begin
		if (wr_en)
			mem_q[wr_ptr_q] <= wr_data_i;
	end

	// Pointers, occupancy and clear-to-send
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			cts_q    <= 1'b1; // Empty, so room to send
		end
		else
		begin
			if (wr_en)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (rd_en)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q; // Idle or both
			endcase
			cts_q <= (count_q < (ADDR_BITS+1)'(HIGH_WATER)); // Last edge's count
		end
	end

	// Write attempts while full must leave the queue untouched
	a_no_write_full: assert property (@(posedge clk_i) disable iff (rst_i)
		(count_q == DEPTH) && wr_vld_i && !rd_en |=> $stable(wr_ptr_q) && (count_q == DEPTH));

	// Occupancy bounded and consistent with the pointers
	a_occupancy: assert property (@(posedge clk_i) disable iff (rst_i)
		(count_q <= DEPTH) && (count_q == {1'b0, wr_ptr_q - rd_ptr_q}));

endmodule

`default_nettype wire

// File: hdl/link_chan_if.sv
//////////////////////////////////////////////////////////////////////
// Link channel bundle, all receive channels plus transmit channel 0
// Transfer on any edge where vld and rdy are both high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface link_chan_if;

	// Receive side, one entry per channel
	raggedstone_pkg::pkt_t                 rx_data [raggedstone_pkg::NUM_CHANS];
	logic [raggedstone_pkg::NUM_CHANS-1:0] rx_vld;
	logic [raggedstone_pkg::NUM_CHANS-1:0] rx_rdy;

	// Transmit side, channel 0 only
	raggedstone_pkg::pkt_t tx_data;
	logic                  tx_vld;
	logic                  tx_rdy;

	// Consumer of received traffic
	modport rx_sink (input rx_data, input rx_vld, output rx_rdy);

	// Producer toward the link
	modport tx_src (output tx_data, output tx_vld, input tx_rdy);

	// Handshake observer, no data
	modport monitor (input rx_vld, input rx_rdy, input tx_vld, input tx_rdy);

endinterface

`default_nettype wire

// File: hdl/raggedstone_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types and tuning defaults for the slow-side packet bridge
// Packets are opaque 72-bit words, header and payload are not split
// Timing defaults assume the 37.5 MHz LED clock of the board
//////////////////////////////////////////////////////////////////////

`default_nettype none

package raggedstone_pkg;

	//////////////////////////////////////////////////////////////////////
	// Packet format
	//////////////////////////////////////////////////////////////////////

	localparam int PKT_BITS = 72; // Header plus payload
	typedef logic [PKT_BITS-1:0] pkt_t;

	localparam int NUM_CHANS = 8; // Link channels, only 0 is used

	//////////////////////////////////////////////////////////////////////
	// Status LEDs
	//////////////////////////////////////////////////////////////////////

	localparam int NUM_LEDS = 2;
	localparam int LED_LINK = 0; // Link to the machine
	localparam int LED_HOST = 1; // Host packet port

	// Default tuning, overridden from the top level
	localparam int DEF_FIFO_ADDR_BITS = 4; // 15 usable entries
	localparam int DEF_HIGH_WATER     = 8; // CTS drops at this occupancy
	localparam int DEF_PULSE_CYCLES   = 3750000; // Roughly 100 ms dark
	localparam int DEF_BLINK_BIT      = 21; // Error blink counter bit

endpackage

`default_nettype wire
